// File: verilog/ecc_pkg.sv
package ecc_pkg;

  // ==================================================
  // Code geometry of the 0xB7 distance-4 code
  // ==================================================
  localparam int ECC_WIDTH      = 7;
  localparam int MAX_DATA_WIDTH = 56;  // Largest data word the polynomial protects

  typedef logic [ECC_WIDTH-1:0] ecc_check_t;     // Check bits as stored next to the data
  typedef logic [ECC_WIDTH-1:0] ecc_syndrome_t;  // Stored check bits XOR recomputed ones

  // Syndrome column of data bit idx
  // Check bit k has the unit column 1 << k, so no data column may be a power of two
  function automatic ecc_syndrome_t ecc_column(input int unsigned idx);
    case (idx)
      0:  ecc_column = 7'h37;
      1:  ecc_column = 7'h6e;
      2:  ecc_column = 7'h6b;
      3:  ecc_column = 7'h61;
      4:  ecc_column = 7'h75;
      5:  ecc_column = 7'h5d;
      6:  ecc_column = 7'h0d;
      7:  ecc_column = 7'h1a;
      8:  ecc_column = 7'h34;
      9:  ecc_column = 7'h68;
      10: ecc_column = 7'h67;
      11: ecc_column = 7'h79;
      12: ecc_column = 7'h45;
      13: ecc_column = 7'h3d;
      14: ecc_column = 7'h7a;
      15: ecc_column = 7'h43;
      16: ecc_column = 7'h31;
      17: ecc_column = 7'h62;
      18: ecc_column = 7'h73;
      19: ecc_column = 7'h51;
      20: ecc_column = 7'h15;
      21: ecc_column = 7'h2a;
      22: ecc_column = 7'h54;
      23: ecc_column = 7'h1f;
      24: ecc_column = 7'h3e;
      25: ecc_column = 7'h7c;
      26: ecc_column = 7'h4f;
      27: ecc_column = 7'h29;
      28: ecc_column = 7'h52;
      29: ecc_column = 7'h13;
      30: ecc_column = 7'h26;
      31: ecc_column = 7'h4c;
      32: ecc_column = 7'h2f;
      33: ecc_column = 7'h5e;
      34: ecc_column = 7'h0b;
      35: ecc_column = 7'h16;
      36: ecc_column = 7'h2c;
      37: ecc_column = 7'h58;
      38: ecc_column = 7'h07;
      39: ecc_column = 7'h0e;
      40: ecc_column = 7'h1c;
      41: ecc_column = 7'h38;
      42: ecc_column = 7'h70;
      43: ecc_column = 7'h57;
      44: ecc_column = 7'h19;
      45: ecc_column = 7'h32;
      46: ecc_column = 7'h64;
      47: ecc_column = 7'h7f;
      48: ecc_column = 7'h49;
      49: ecc_column = 7'h25;
      50: ecc_column = 7'h4a;
      51: ecc_column = 7'h23;
      52: ecc_column = 7'h46;
      53: ecc_column = 7'h3b;
      54: ecc_column = 7'h76;
      55: ecc_column = 7'h5b;
      default: ecc_column = '0;  // Outside the code, contributes nothing
    endcase
  endfunction

endpackage

// File: verilog/mem_pkg.sv
package mem_pkg;

  // ==================================================
  // Memory addressing and event counters
  // ==================================================
  localparam int MAX_ADDR_WIDTH = 16;  // Upper bound for the array depth parameter
  localparam int CNT_WIDTH      = 16;

  typedef logic [CNT_WIDTH-1:0] err_count_t;

  // Increment that sticks at all ones
  function automatic err_count_t count_inc(input err_count_t cnt);
    err_count_t next_cnt;
    if (&cnt) begin
      next_cnt = cnt;
    end else begin
      next_cnt = err_count_t'(cnt + 1'b1);
    end
    return next_cnt;
  endfunction

endpackage

// File: verilog/ecc_7_hd4_encode.sv
`timescale 1ns/100ps

module ecc_7_hd4_encode import ecc_pkg::*; #(
  parameter int DATA_WIDTH = 32
) (
  input  logic [DATA_WIDTH-1:0] i_data,
  output ecc_check_t            o_ecc
);

  // ==================================================
  // Check bit generation
  // ==================================================

  // Check bit k is the parity over all data bits whose column has bit k set,
  // so XOR-ing the masked columns of the set data bits gives all seven at once
  always_comb begin
    o_ecc = '0;
    for (int n = 0; n < DATA_WIDTH; n++) begin
      o_ecc = o_ecc ^ ({ECC_WIDTH{i_data[n]}} & ecc_column(n));
    end
  end

  // Beyond 56 bits the columns run out and would alias to zero
  a_data_width: assert final (DATA_WIDTH >= 1 && DATA_WIDTH <= MAX_DATA_WIDTH)
    else $error("ecc_7_hd4_encode: DATA_WIDTH %0d outside 1..%0d",
                DATA_WIDTH, MAX_DATA_WIDTH);

endmodule

// File: verilog/ecc_memory.sv
`timescale 1ns/100ps

module ecc_memory import ecc_pkg::*; import mem_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 6
) (
  input  logic                          i_clk,
  input  logic                          i_rst,
  // Write side
  input  logic                          i_wr_en,
  input  logic [ADDR_WIDTH-1:0]         i_wr_addr,
  input  logic [DATA_WIDTH-1:0]         i_wr_data,
  input  logic [DATA_WIDTH+ECC_WIDTH-1:0] i_inject_mask,  // Check bits in the upper 7 bits
  // Read side
  input  logic                          i_rd_en,
  input  logic [ADDR_WIDTH-1:0]         i_rd_addr,
  output logic                          o_rd_valid,
  output logic [ADDR_WIDTH-1:0]         o_rd_addr,
  output logic [DATA_WIDTH-1:0]         o_rd_data,
  output ecc_check_t                    o_rd_check
);

  localparam int WORD_WIDTH = DATA_WIDTH + ECC_WIDTH;
  localparam int DEPTH      = 1 << ADDR_WIDTH;

  ecc_check_t            wr_check;
  logic [WORD_WIDTH-1:0] wr_word;
  logic [WORD_WIDTH-1:0] mem [0:DEPTH-1];
  logic [WORD_WIDTH-1:0] rd_word;

  // ==================================================
  // Write path with fault injection
  // ==================================================
  ecc_7_hd4_encode #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_encode (
    .i_data (i_wr_data),
    .o_ecc  (wr_check)
  );

  // A zero mask stores the clean codeword
  assign wr_word = {wr_check, i_wr_data} ^ i_inject_mask;

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= wr_word;
    end
  end

  // ==================================================
  // Registered read
  // ==================================================

  // Same-address write in this cycle is not visible yet, the old word comes out
  always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
      rd_word   <= mem[i_rd_addr];
      o_rd_addr <= i_rd_addr;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= i_rd_en;
    end
  end

  assign o_rd_data  = rd_word[DATA_WIDTH-1:0];
  assign o_rd_check = rd_word[WORD_WIDTH-1:DATA_WIDTH];

  // The whole pipeline sizes its address fields from this parameter
  a_addr_width: assert final (ADDR_WIDTH >= 1 && ADDR_WIDTH <= MAX_ADDR_WIDTH)
    else $error("ecc_memory: ADDR_WIDTH %0d outside 1..%0d", ADDR_WIDTH, MAX_ADDR_WIDTH);

endmodule

// File: verilog/ecc_7_hd4_syndrome.sv
`timescale 1ns/100ps

module ecc_7_hd4_syndrome import ecc_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 6
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [DATA_WIDTH-1:0] i_data,
  input  ecc_check_t            i_check,
  output logic                  o_valid,
  output logic [ADDR_WIDTH-1:0] o_addr,
  output logic [DATA_WIDTH-1:0] o_data,
  output ecc_syndrome_t         o_syndrome
);

  ecc_check_t calc_check;

  // ==================================================
  // Decode stage
  // ==================================================
  ecc_7_hd4_encode #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_recompute (
    .i_data (i_data),
    .o_ecc  (calc_check)
  );

  // Syndrome is forced to zero between reads so the corrector sees a clean
  // word and raises no flag while nothing is in flight
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid    <= 1'b0;
      o_syndrome <= '0;
    end else begin
      o_valid    <= i_valid;
      o_syndrome <= i_valid ? (i_check ^ calc_check) : '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_data <= i_data;  // Raw word, correction happens in the next stage
      o_addr <= i_addr;
    end
  end

endmodule

// File: verilog/ecc_7_hd4_correct.sv
`timescale 1ns/100ps

module ecc_7_hd4_correct import ecc_pkg::*; #(
  parameter int DATA_WIDTH = 32
) (
  input  ecc_syndrome_t         i_ecc,
  input  logic [DATA_WIDTH-1:0] i_data,
  input  logic                  i_disable,  // Data stays raw, the flags are still reported
  output logic [DATA_WIDTH-1:0] o_data,
  output logic                  o_corrected,
  output logic                  o_detected
);

  logic [DATA_WIDTH-1:0] fixed_data;

  assign o_data = i_disable ? i_data : fixed_data;

  // ==================================================
  // Syndrome classification
  // ==================================================
  always_comb begin
    // Anything not matched below is a multi-bit error
    o_corrected = 1'b0;
    o_detected  = 1'b1;
    fixed_data  = i_data;

    // Clean word
    if (i_ecc == '0) begin
      o_detected = 1'b0;
    end

    // Unit syndrome points at a stored check bit, the data itself is fine
    for (int k = 0; k < ECC_WIDTH; k++) begin
      if (i_ecc == ecc_syndrome_t'(1 << k)) begin
        o_corrected = 1'b1;
        o_detected  = 1'b0;
      end
    end

    // Column match names the flipped data bit
    for (int n = 0; n < DATA_WIDTH; n++) begin
      if (i_ecc == ecc_column(n)) begin
        o_corrected   = 1'b1;
        o_detected    = 1'b0;
        fixed_data[n] = ~i_data[n];
      end
    end
  end

  // Columns are distinct from zero and from the unit vectors, so exactly one
  // class can hold for any syndrome
  a_flags_exclusive: assert final (!(o_corrected && o_detected))
    else $error("ecc_7_hd4_correct: corrected and detected both set, syndrome %h", i_ecc);

endmodule

// File: verilog/ecc_event_log.sv
`timescale 1ns/100ps

module ecc_event_log import ecc_pkg::*; import mem_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 6
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [DATA_WIDTH-1:0] i_data,
  input  logic                  i_corrected,
  input  logic                  i_detected,
  input  logic                  i_clr_counts,
  output logic                  o_rd_valid,
  output logic [DATA_WIDTH-1:0] o_rd_data,
  output logic                  o_corrected,
  output logic                  o_detected,
  output err_count_t            o_corr_count,
  output err_count_t            o_det_count,
  output logic [ADDR_WIDTH-1:0] o_last_err_addr
);

  // ==================================================
  // Result register and event counters
  // ==================================================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rd_valid      <= 1'b0;
      o_corrected     <= 1'b0;
      o_detected      <= 1'b0;
      o_corr_count    <= '0;
      o_det_count     <= '0;
      o_last_err_addr <= '0;
    end else begin
      o_rd_valid  <= i_valid;
      o_corrected <= i_valid & i_corrected;
      o_detected  <= i_valid & i_detected;

      if (i_clr_counts) begin  // Clear wins over an event in the same cycle
        o_corr_count <= '0;
        o_det_count  <= '0;
      end else begin
        if (i_valid && i_corrected) o_corr_count <= count_inc(o_corr_count);
        if (i_valid && i_detected)  o_det_count  <= count_inc(o_det_count);
      end

      if (i_valid && (i_corrected || i_detected)) begin
        o_last_err_addr <= i_addr;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rd_data <= i_data;
    end
  end

  // The syndrome stage zeroes its syndrome between reads, so the corrector
  // must stay quiet whenever no read is in flight
  a_flag_needs_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_corrected || i_detected) |-> i_valid)
    else $error("ecc_event_log: error flag without a valid read");

  a_data_width: assert final (DATA_WIDTH <= MAX_DATA_WIDTH)
    else $error("ecc_event_log: DATA_WIDTH %0d above %0d", DATA_WIDTH, MAX_DATA_WIDTH);

endmodule

// File: verilog/ecc_ram_top.sv
`timescale 1ns/100ps

module ecc_ram_top import ecc_pkg::*; import mem_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 6
) (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic                            i_wr_en,
  input  logic [ADDR_WIDTH-1:0]           i_wr_addr,
  input  logic [DATA_WIDTH-1:0]           i_wr_data,
  input  logic [DATA_WIDTH+ECC_WIDTH-1:0] i_inject_mask,
  input  logic                            i_rd_en,
  input  logic [ADDR_WIDTH-1:0]           i_rd_addr,
  input  logic                            i_disable,
  input  logic                            i_clr_counts,
  output logic                            o_rd_valid,
  output logic [DATA_WIDTH-1:0]           o_rd_data,
  output logic                            o_corrected,
  output logic                            o_detected,
  output err_count_t                      o_corr_count,
  output err_count_t                      o_det_count,
  output logic [ADDR_WIDTH-1:0]           o_last_err_addr
);

  logic                  mem_rd_valid;
  logic [ADDR_WIDTH-1:0] mem_rd_addr;
  logic [DATA_WIDTH-1:0] mem_rd_data;
  ecc_check_t            mem_rd_check;
  logic                  syn_valid;
  logic [ADDR_WIDTH-1:0] syn_addr;
  logic [DATA_WIDTH-1:0] syn_data;
  ecc_syndrome_t         syn_syndrome;
  logic [DATA_WIDTH-1:0] cor_data;
  logic                  cor_corrected;
  logic                  cor_detected;

  // ==================================================
  // Read pipeline, memory -> decode -> execute -> result
  // ==================================================
  ecc_memory #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_memory (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_wr_en       (i_wr_en),
    .i_wr_addr     (i_wr_addr),
    .i_wr_data     (i_wr_data),
    .i_inject_mask (i_inject_mask),
    .i_rd_en       (i_rd_en),
    .i_rd_addr     (i_rd_addr),
    .o_rd_valid    (mem_rd_valid),
    .o_rd_addr     (mem_rd_addr),
    .o_rd_data     (mem_rd_data),
    .o_rd_check    (mem_rd_check)
  );

  ecc_7_hd4_syndrome #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_syndrome (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (mem_rd_valid),
    .i_addr     (mem_rd_addr),
    .i_data     (mem_rd_data),
    .i_check    (mem_rd_check),
    .o_valid    (syn_valid),
    .o_addr     (syn_addr),
    .o_data     (syn_data),
    .o_syndrome (syn_syndrome)
  );

  ecc_7_hd4_correct #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_correct (
    .i_ecc       (syn_syndrome),
    .i_data      (syn_data),
    .i_disable   (i_disable),
    .o_data      (cor_data),
    .o_corrected (cor_corrected),
    .o_detected  (cor_detected)
  );

  ecc_event_log #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_event_log (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (syn_valid),
    .i_addr          (syn_addr),
    .i_data          (cor_data),
    .i_corrected     (cor_corrected),
    .i_detected      (cor_detected),
    .i_clr_counts    (i_clr_counts),
    .o_rd_valid      (o_rd_valid),
    .o_rd_data       (o_rd_data),
    .o_corrected     (o_corrected),
    .o_detected      (o_detected),
    .o_corr_count    (o_corr_count),
    .o_det_count     (o_det_count),
    .o_last_err_addr (o_last_err_addr)
  );

endmodule

// File: sim/tb_ecc_ram.sv
`timescale 1ns/100ps

module tb_ecc_ram import ecc_pkg::*; import mem_pkg::*; ();

  localparam int DW      = 32;
  localparam int AW      = 6;
  localparam int MW      = DW + ECC_WIDTH;  // Injection mask width with the check bits on top
  localparam int DEPTH   = 1 << AW;
  localparam int LATENCY = 3;
  localparam int TIMEOUT = 10;

  logic          clk, rst;
  logic          wr_en, rd_en, dis, clr;
  logic [AW-1:0] wr_addr, rd_addr;
  logic [DW-1:0] wr_data;
  logic [MW-1:0] inj_mask;
  logic          rd_valid, corrected, detected;
  logic [DW-1:0] rd_data;
  err_count_t    corr_count, det_count;
  logic [AW-1:0] last_err_addr;

  // Model of what was written and how it was corrupted
  logic [DW-1:0] shadow_data [0:DEPTH-1];
  logic [MW-1:0] shadow_mask [0:DEPTH-1];

  integer seed;
  int     err_count, tests_run, tests_failed;
  bit     timed_out;

  ecc_ram_top #(
    .DATA_WIDTH (DW),
    .ADDR_WIDTH (AW)
  ) uut (
    .i_clk (clk), .i_rst (rst),
    .i_wr_en (wr_en), .i_wr_addr (wr_addr), .i_wr_data (wr_data), .i_inject_mask (inj_mask),
    .i_rd_en (rd_en), .i_rd_addr (rd_addr), .i_disable (dis), .i_clr_counts (clr),
    .o_rd_valid (rd_valid), .o_rd_data (rd_data),
    .o_corrected (corrected), .o_detected (detected),
    .o_corr_count (corr_count), .o_det_count (det_count), .o_last_err_addr (last_err_addr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==================================================
  // Stimulus helpers and reference model
  // ==================================================
  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [DW-1:0] rand_word();
    return DW'({$random(seed), $random(seed)});
  endfunction

  function automatic logic [MW-1:0] single_mask(input int b);
    logic [MW-1:0] m;
    m    = '0;
    m[b] = 1'b1;
    return m;
  endfunction

  function automatic logic [MW-1:0] double_mask();
    int b1, b2;
    b1 = rand_below(MW);
    b2 = (b1 + 1 + rand_below(MW - 1)) % MW;  // Never equal to b1
    return single_mask(b1) | single_mask(b2);
  endfunction

  // One flip is corrected while two flips are only flagged and come back as stored
  task automatic model_read(input int addr, input bit dis_on, output logic [DW-1:0] exp_data,
                            output bit exp_corr, output bit exp_det);
    logic [DW-1:0] flips;
    int            nflips;
    flips    = shadow_mask[addr][DW-1:0];
    nflips   = $countones(shadow_mask[addr]);
    exp_data = shadow_data[addr];
    exp_corr = (nflips == 1);
    exp_det  = (nflips == 2);
    if (exp_det || (exp_corr && dis_on)) exp_data = exp_data ^ flips;
  endtask

  task automatic write_word(input int addr, input logic [DW-1:0] data, input logic [MW-1:0] mask);
    wr_en    = 1'b1;
    wr_addr  = addr;
    wr_data  = data;
    inj_mask = mask;
    @(negedge clk);
    wr_en    = 1'b0;
    inj_mask = '0;
    shadow_data[addr] = data;
    shadow_mask[addr] = mask;
  endtask

  task automatic compare_result(input int addr, input logic [DW-1:0] got, input logic got_corr,
                                input logic got_det);
    logic [DW-1:0] exp_data;
    bit            exp_corr, exp_det;
    model_read(addr, dis, exp_data, exp_corr, exp_det);
    if (got !== exp_data || got_corr !== exp_corr || got_det !== exp_det) begin
      $display("** Error at %0t: addr %0d read %h c%b d%b, expected %h c%b d%b", $time, addr,
               got, got_corr, got_det, exp_data, exp_corr, exp_det);
      err_count++;
    end
  endtask

  // Issues a single read and checks the result and the fixed latency
  task automatic read_check(input int addr);
    int lat;
    if (timed_out) return;
    rd_en   = 1'b1;
    rd_addr = addr;
    @(negedge clk);
    rd_en = 1'b0;
    lat   = 1;
    while (!rd_valid && lat < TIMEOUT) begin
      @(negedge clk);
      lat++;
    end
    if (!rd_valid) begin
      $display("Read of address %0d got no o_rd_valid within %0d cycles", addr, TIMEOUT);
      timed_out = 1'b1;
      err_count++;
    end else begin
      if (lat != LATENCY) begin
        $display("** Error at %0t: read latency %0d, expected %0d", $time, lat, LATENCY);
        err_count++;
      end
      compare_result(addr, rd_data, corrected, detected);
    end
  endtask

  task automatic clear_counts();
    clr = 1'b1;
    @(negedge clk);
    clr = 1'b0;
    if (corr_count !== '0 || det_count !== '0) begin
      $display("** Error at %0t: counts %0d/%0d after clear, expected 0", $time,
               corr_count, det_count);
      err_count++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    int errs;
    errs = err_count - errs_before;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("Test %0d %s: %s, %0d error(s)", num, name, (errs != 0) ? "FAILED" : "ok", errs);
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic clean_rw_test();
    int e0;
    e0 = err_count;
    for (int a = 0; a < DEPTH; a++) write_word(a, rand_word(), '0);
    for (int a = 0; a < DEPTH; a++) read_check(a);
    report_test(1, "clean write and read", e0);
  endtask

  task automatic single_data_test();
    int e0;
    e0 = err_count;
    for (int b = 0; b < DW; b++) begin
      write_word(b % DEPTH, rand_word(), single_mask(b));
      read_check(b % DEPTH);
    end
    report_test(2, "single data-bit error", e0);
  endtask

  task automatic single_check_test();
    int e0;
    e0 = err_count;
    for (int k = 0; k < ECC_WIDTH; k++) begin
      write_word(k, rand_word(), single_mask(DW + k));
      read_check(k);
    end
    report_test(3, "single check-bit error", e0);
  endtask

  task automatic double_error_test();
    int e0;
    e0 = err_count;
    for (int i = 0; i < 24; i++) begin
      write_word(i, rand_word(), double_mask());
      read_check(i);
    end
    report_test(4, "double-bit error", e0);
  endtask

  task automatic disable_test();
    int e0;
    e0  = err_count;
    dis = 1'b1;
    for (int i = 0; i < 8; i++) begin
      write_word(i, rand_word(), single_mask(rand_below(DW)));
      read_check(i);
    end
    write_word(8, rand_word(), single_mask(DW + 2));  // Check-bit flip leaves data intact
    read_check(8);
    dis = 1'b0;
    report_test(5, "correction disabled", e0);
  endtask

  task automatic counter_test();
    int            e0, exp_corr_n, exp_det_n, exp_last, n, idle;
    int            addrs[$];
    logic [DW-1:0] exp_data;
    bit            c, d;
    e0 = err_count;
    clear_counts();
    exp_corr_n = 0;
    exp_det_n  = 0;
    exp_last   = 0;
    for (int i = 0; i < 18; i++) begin
      case (i % 3)
        0:       write_word(i, rand_word(), '0);
        1:       write_word(i, rand_word(), single_mask(rand_below(MW)));
        default: write_word(i, rand_word(), double_mask());
      endcase
      addrs.push_back((i * 7 + 1) % 18);  // Shuffled order over the same words, clean word last
    end
    foreach (addrs[j]) begin
      model_read(addrs[j], 1'b0, exp_data, c, d);
      exp_corr_n += c;
      exp_det_n  += d;
      if (c || d) exp_last = addrs[j];
    end
    n    = 0;
    idle = 0;
    fork
      begin
        foreach (addrs[j]) begin
          rd_en   = 1'b1;
          rd_addr = addrs[j];
          @(negedge clk);
        end
        rd_en = 1'b0;
      end
      begin
        while (n < addrs.size() && idle < TIMEOUT) begin
          @(negedge clk);
          if (rd_valid) begin
            compare_result(addrs[n], rd_data, corrected, detected);
            n++;
            idle = 0;
          end else begin
            idle++;
          end
        end
      end
    join
    if (n != addrs.size()) begin
      $display("Back-to-back reads stalled, %0d of %0d results arrived", n, addrs.size());
      timed_out = 1'b1;
      err_count++;
    end
    if (corr_count != exp_corr_n || det_count != exp_det_n || last_err_addr != exp_last) begin
      $display("** Error at %0t: counts %0d/%0d last %0d, expected %0d/%0d last %0d", $time,
               corr_count, det_count, last_err_addr, exp_corr_n, exp_det_n, exp_last);
      err_count++;
    end
    clear_counts();
    report_test(6, "counters and back-to-back reads", e0);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    seed         = 31729;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    rst      = 1'b1;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    dis      = 1'b0;
    clr      = 1'b0;
    wr_addr  = '0;
    rd_addr  = '0;
    wr_data  = '0;
    inj_mask = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (rd_valid !== 1'b0 || corrected !== 1'b0 || detected !== 1'b0 ||
        corr_count !== '0 || det_count !== '0) begin
      $display("** Error at %0t: outputs not idle after reset", $time);
      err_count++;
    end

    clean_rw_test();
    single_data_test();
    single_check_test();
    double_error_test();
    disable_test();
    counter_test();

    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: build.f
verilog/ecc_pkg.sv
verilog/mem_pkg.sv
verilog/ecc_7_hd4_encode.sv
verilog/ecc_memory.sv
verilog/ecc_7_hd4_syndrome.sv
verilog/ecc_7_hd4_correct.sv
verilog/ecc_event_log.sv
verilog/ecc_ram_top.sv
sim/tb_ecc_ram.sv
